// File: files.f
+incdir+testbench
hdl/gpioPkg.sv
hdl/busAccessUnit.sv
hdl/gpioRegs.sv
hdl/gpioPinDriver.sv
hdl/gpioSubsystem.sv
testbench/gpioTb.sv

// File: Makefile
# Verilator build and run for the GPIO subsystem testbench

VERILATOR ?= verilator
TOP       ?= gpioTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= sim passed

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) testbench/gpioTests.svh

.PHONY: compile run clean

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass line
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/gpioTests.svh
    // ##############################
    // Reference model
    // ##############################
    // Byte anywhere, half on even offsets, word on offset zero
    function automatic logic isAligned(input logic [15:0] addr, input gpioPkg::accessSize_e size);
        return size == gpioPkg::sizeByte || (!addr[0] && (size == gpioPkg::sizeHalf || !addr[1]));
    endfunction

    function automatic logic [31:0] mergeStore(input logic [31:0] old, input logic [1:0] offset,
            input gpioPkg::accessSize_e size, input logic [31:0] data);
        logic [31:0] merged;
        merged = old;
        case (size)
            gpioPkg::sizeByte: merged[offset*8 +: 8]  = data[7:0];   // One lane
            gpioPkg::sizeHalf: merged[offset*8 +: 16] = data[15:0];  // Two lanes
            default:           merged = data;
        endcase
        return merged;
    endfunction

    function automatic logic [31:0] loadValue(input logic [31:0] word, input logic [1:0] offset,
            input gpioPkg::accessSize_e size, input logic isSigned);
        logic [7:0]  byteVal;
        logic [15:0] halfVal;
        byteVal = word[offset*8 +: 8];
        halfVal = word[offset*8 +: 16];
        if (size == gpioPkg::sizeByte)
            return isSigned ? 32'($signed(byteVal)) : 32'(byteVal);
        if (size == gpioPkg::sizeHalf)
            return isSigned ? 32'($signed(halfVal)) : 32'(halfVal);
        return word;
    endfunction

    // Enabled pins carry the output bit, the rest float
    task automatic checkPins(input int port);
        logic [31:0] enable;
        enable = model[port*4 + 1];
        @(negedge clk);
        checkValue(ioPin[port*32 +: 32] & enable, model[port*4 + 2] & enable, "driven pins");
        checkValue(pinFloat[port*32 +: 32], ~enable, "released pins");
    endtask

    task automatic checkRegs();
        for (int p = 0; p < portCount; p++)
        begin
            readCheck(p*16 + 4, gpioPkg::sizeWord, 1'b0, model[p*4 + 1], "enable word");
            readCheck(p*16 + 8, gpioPkg::sizeWord, 1'b0, model[p*4 + 2], "output data word");
        end
    endtask

    // ##############################
    // Directed tests
    // ##############################
    task automatic resetStateTest();
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            checkValue({31'd0, rdValid}, 0, "rdValid before any read");
        end
        for (int p = 0; p < portCount; p++)
            checkPins(p);                           // Everything released
        checkRegs();
    endtask

    task automatic wordReadbackTest();
        for (int p = 0; p < portCount; p++)
        begin
            writeBus(p*16 + 4, gpioPkg::sizeWord, nextRandom(32));
            writeBus(p*16 + 8, gpioPkg::sizeWord, nextRandom(32));
        end
        checkRegs();
        @(posedge clk);
        req <= makeReq(4, gpioPkg::sizeWord, 1'b0, 1'b0, '0);
        @(posedge clk);
        req <= makeReq(24, gpioPkg::sizeWord, 1'b0, 1'b0, '0);    // Next cycle, no gap
        @(negedge clk);
        checkValue({31'd0, rdValid}, 1, "first back-to-back valid");
        checkValue(rdData, model[1], "first back-to-back data");
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        checkValue({31'd0, rdValid}, 1, "second back-to-back valid");
        checkValue(rdData, model[6], "second back-to-back data");
    endtask

    task automatic laneAccessTest();
        logic [31:0] patterns [3];
        patterns = '{32'h807F_FF01, 32'h7F80_01FF, nextRandom(32)};   // Both sign cases
        writeBus(8, gpioPkg::sizeWord, nextRandom(32));
        for (int off = 0; off < 4; off++)
        begin
            writeBus(8 + off, gpioPkg::sizeByte, nextRandom(8));
            readCheck(8, gpioPkg::sizeWord, 1'b0, model[2], "word after byte store");
            if (off % 2 == 0)
            begin
                writeBus(8 + off, gpioPkg::sizeHalf, nextRandom(16));
                readCheck(8, gpioPkg::sizeWord, 1'b0, model[2], "word after half store");
            end
        end
        foreach (patterns[i])
        begin
            writeBus(8, gpioPkg::sizeWord, patterns[i]);
            for (int k = 0; k < 8; k++)             // Offset k/2, signed flag k%2
            begin
                readCheck(8 + k/2, gpioPkg::sizeByte, k[0],
                          loadValue(model[2], 2'(k/2), gpioPkg::sizeByte, k[0]), "byte load");
                if (k % 4 < 2)
                    readCheck(8 + k/2, gpioPkg::sizeHalf, k[0],
                              loadValue(model[2], 2'(k/2), gpioPkg::sizeHalf, k[0]), "half load");
            end
        end
    endtask

    task automatic outputDriveTest();
        writeBus(16 + 4, gpioPkg::sizeWord, 32'hF0F0_A55A);
        writeBus(16 + 8, gpioPkg::sizeWord, nextRandom(32));
        for (int p = 0; p < portCount; p++)
            checkPins(p);
    endtask

    task automatic inputSampleTest();
        logic [31:0] enable;
        logic [31:0] expected;
        for (int p = 0; p < portCount; p++)
        begin
            enable = model[p*4 + 1];
            @(posedge clk);
            tbEnable[p*32 +: 32] <= ~enable;        // Outside drives released pins only
            tbDrive[p*32 +: 32]  <= nextRandom(32);
            repeat (3) @(posedge clk);              // Two sync flops and the snapshot
            expected = (tbDrive[p*32 +: 32] & ~enable) | (model[p*4 + 2] & enable);
            readCheck(p*16, gpioPkg::sizeWord, 1'b0, expected, "data-in snapshot");
            writeBus(p*16, gpioPkg::sizeWord, ~expected);
            writeBus(p*16 + 12, gpioPkg::sizeWord, nextRandom(32));
            readCheck(p*16, gpioPkg::sizeWord, 1'b0, expected, "data-in after stores");
            readCheck(p*16 + 12, gpioPkg::sizeWord, 1'b0, 32'd0, "reserved word");
        end
        @(posedge clk);
        tbEnable <= '0;
    endtask

    task automatic badAccessTest();
        logic [31:0] ignored;
        busAccess(makeReq(5, gpioPkg::sizeHalf, 1'b0, 1'b1, nextRandom(32)), ignored);
        busAccess(makeReq(7, gpioPkg::sizeHalf, 1'b0, 1'b0, '0), ignored);
        for (int off = 1; off < 4; off++)
        begin
            busAccess(makeReq(8 + off, gpioPkg::sizeWord, 1'b0, 1'b1, nextRandom(32)), ignored);
            busAccess(makeReq(20 + off, gpioPkg::sizeWord, 1'b0, 1'b0, '0), ignored);
        end
        writeBus(portCount*16 + 4, gpioPkg::sizeWord, nextRandom(32));   // Past the last port
        checkRegs();
        readCheck(portCount*16 + 4, gpioPkg::sizeWord, 1'b0, 32'd0, "unmapped read");
    endtask

// File: testbench/gpioTb.sv
`timescale 1ns/1ps

module gpioTb;

    localparam int portCount = 2;                   // Two ports of 32 pins
    localparam int pinCount  = portCount * 32;
    localparam int waitLimit = 16;                  // Cycles before a wait gives up

    logic                 clk;
    logic                 rstn;
    gpioPkg::busReq_t     req;                      // CPU side request
    logic [31:0]          rdData;
    logic                 rdValid;
    logic                 accessError;
    wire  [pinCount-1:0]  ioPin;
    logic [pinCount-1:0]  tbDrive;                  // Level from the outside world
    logic [pinCount-1:0]  tbEnable;                 // Outside drive enable
    logic [pinCount-1:0]  pinFloat;                 // Pin left at high impedance
    logic [31:0]          model [portCount*4];      // Expected word per word address
    logic [15:0]          lfsrState;
    int                   errorCount;
    int                   timeoutCount;

    // ##############################
    // Clock, DUT and pin model
    // ##############################
    initial clk = 1'b0;
    always #20 clk = ~clk;                          // 40 ns period

    gpioSubsystem #(
        .portCount   (portCount)
    ) dut (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .rdData      (rdData),
        .rdValid     (rdValid),
        .accessError (accessError),
        .ioPin       (ioPin)
    );

    genvar g;
    generate
        for (g = 0; g < pinCount; g++)
        begin : pinModel
            assign ioPin[g]    = tbEnable[g] ? tbDrive[g] : 1'bz;  // Outside driver
            assign pinFloat[g] = (ioPin[g] === 1'bz);
        end
    endgenerate

    // ##############################
    // Check and random source
    // ##############################
    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        if (actual !== expected)
        begin
            errorCount++;
            $display("FAILED at time %0t: %s, got %08h, expected %08h",
                     $time, msg, actual, expected);
        end
    endtask

    // Taps 16 14 13 11 with one step per bit taken
    function automatic logic [31:0] nextRandom(input int bitCount);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < bitCount; i++)
        begin
            feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
            value     = {value[30:0], feedback};
        end
        return value;
    endfunction

    // ##############################
    // Bus access
    // ##############################
    function automatic gpioPkg::busReq_t makeReq(input int addr, input gpioPkg::accessSize_e size,
            input logic isSigned, input logic isWrite, input logic [31:0] data);
        gpioPkg::busReq_t r;
        r.addr     = 16'(addr);
        r.size     = size;
        r.isSigned = isSigned;
        r.wrData   = data;
        r.wrEn     = isWrite;
        r.rdEn     = ~isWrite;
        return r;
    endfunction

    // One strobe followed by the load data or the error pulse
    task automatic busAccess(input gpioPkg::busReq_t r, output logic [31:0] data);
        int   cycles;
        logic bad;
        bad  = !isAligned(r.addr, r.size);
        data = '0;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;                                  // Back to idle
        if (r.rdEn || bad)
        begin
            cycles = 0;
            do
            begin
                @(negedge clk);
                cycles++;
            end
            while (rdValid !== 1'b1 && accessError !== 1'b1 && cycles < waitLimit);
            if (rdValid !== 1'b1 && accessError !== 1'b1)
            begin
                timeoutCount++;
                $display("Timed out waiting for a response at address %04h", r.addr);
            end
            else
            begin
                checkValue(cycles, 1, "response latency");
                checkValue({30'd0, rdValid, accessError}, {30'd0, !bad, bad}, "response kind");
                data = rdData;
                @(negedge clk);
                checkValue({30'd0, rdValid, accessError}, 0, "response longer than a cycle");
            end
        end
        else
        begin
            @(negedge clk);                         // A legal store answers nothing
            checkValue({30'd0, rdValid, accessError}, 0, "response to a store");
        end
    endtask

    // Store that the model follows when it lands on a writable word
    task automatic writeBus(input int addr, input gpioPkg::accessSize_e size,
                            input logic [31:0] data);
        logic [31:0] ignored;
        if (isAligned(16'(addr), size) && addr < portCount * 16 && addr % 16 inside {[4:11]})
            model[addr / 4] = mergeStore(model[addr / 4], 2'(addr), size, data);
        busAccess(makeReq(addr, size, 1'b0, 1'b1, data), ignored);
    endtask

    task automatic readCheck(input int addr, input gpioPkg::accessSize_e size,
                             input logic isSigned, input logic [31:0] expected, input string msg);
        logic [31:0] data;
        busAccess(makeReq(addr, size, isSigned, 1'b0, '0), data);
        checkValue(data, expected, $sformatf("%s at %04h", msg, addr));
    endtask

    `include "gpioTests.svh"

    // ##############################
    // Test sequence
    // ##############################
    initial
    begin
        errorCount   = 0;
        timeoutCount = 0;
        lfsrState    = 16'd65161;
        for (int i = 0; i < portCount * 4; i++)
            model[i] = '0;                          // Registers come out of reset at zero
        req      <= '0;
        rstn     <= 1'b0;
        tbDrive  <= '0;
        tbEnable <= '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        resetStateTest();
        wordReadbackTest();
        laneAccessTest();
        outputDriveTest();
        inputSampleTest();
        badAccessTest();
        repeat (2) @(posedge clk);
        $display("Errors: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: hdl/gpioSubsystem.sv
`timescale 1ns/1ps

module gpioSubsystem #(
    parameter int portCount = 2
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  gpioPkg::busReq_t          req,
    output logic [31:0]               rdData,
    output logic                      rdValid,
    output logic                      accessError,
    inout  wire  [portCount*32-1:0]   ioPin
);

    gpioPkg::laneWrite_t                lw;         // Store lanes to the registers
    logic [gpioPkg::busAddrWidth-3:0]   rdWordAddr; // Load word address
    logic                               rdEn;       // Aligned load strobe
    logic [31:0]                        regData;    // Registered read word
    logic [portCount*32-1:0]            pinEnable;  // Per pin drive enable
    logic [portCount*32-1:0]            pinOut;     // Per pin drive value
    logic [portCount*32-1:0]            pinSync;    // Synchronized pin levels

    // ##############################
    // Bus side
    // ##############################
    busAccessUnit #(
        .portCount   (portCount)
    ) uBusAccess (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .regData     (regData),
        .lw          (lw),
        .rdWordAddr  (rdWordAddr),
        .rdEn        (rdEn),
        .rdData      (rdData),
        .rdValid     (rdValid),
        .accessError (accessError)
    );

    gpioRegs #(
        .portCount   (portCount)
    ) uRegs (
        .clk         (clk),
        .rstn        (rstn),
        .lw          (lw),
        .rdWordAddr  (rdWordAddr),
        .rdEn        (rdEn),
        .pinSync     (pinSync),
        .regData     (regData),
        .pinEnable   (pinEnable),
        .pinOut      (pinOut)
    );

    // ##############################
    // Pin side
    // ##############################
    gpioPinDriver #(
        .portCount   (portCount)
    ) uPinDriver (
        .clk         (clk),
        .rstn        (rstn),
        .pinEnable   (pinEnable),
        .pinOut      (pinOut),
        .pinSync     (pinSync),
        .ioPin       (ioPin)
    );

endmodule

// File: hdl/gpioPinDriver.sv
`timescale 1ns/1ps

module gpioPinDriver #(
    parameter int portCount = 2
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [portCount*32-1:0]   pinEnable,
    input  logic [portCount*32-1:0]   pinOut,
    output logic [portCount*32-1:0]   pinSync,
    inout  wire  [portCount*32-1:0]   ioPin
);

    localparam int pinCount = portCount * 32;

    logic [pinCount-1:0] syncStage1;                // First synchronizer flop

    // ##############################
    // Tristate drivers
    // ##############################
    genvar i;
    generate
        for (i = 0; i < pinCount; i++)
        begin : pinDrv
            // Drive when enabled, otherwise leave the pin to the outside
            assign ioPin[i] = pinEnable[i] ? pinOut[i] : 1'bz;
        end
    endgenerate

    // ##############################
    // Input synchronizers
    // ##############################
    // Two flops per pin, an undriven pin settles to zero after reset
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            syncStage1 <= '0;
            pinSync    <= '0;
        end
        else
        begin
            syncStage1 <= ioPin;                    // May go metastable
            pinSync    <= syncStage1;               // Stable copy for the snapshot
        end
    end

endmodule

// File: hdl/gpioRegs.sv
`timescale 1ns/1ps

module gpioRegs #(
    parameter int portCount = 2
) (
    input  logic                               clk,
    input  logic                               rstn,
    input  gpioPkg::laneWrite_t                lw,
    input  logic [gpioPkg::busAddrWidth-3:0]   rdWordAddr,
    input  logic                               rdEn,
    input  logic [portCount*32-1:0]            pinSync,
    output logic [31:0]                        regData,
    output logic [portCount*32-1:0]            pinEnable,
    output logic [portCount*32-1:0]            pinOut
);

    localparam int portIdxWidth = gpioPkg::busAddrWidth - 2 - gpioPkg::slotBits;
    localparam int mappedWords  = portCount * gpioPkg::wordsPerPort;

    logic [portIdxWidth-1:0]  wrPort;               // Port selected by the store
    gpioPkg::regSlot_e        wrSlot;               // Slot selected by the store
    logic                     wrMapped;             // Store address inside the map
    logic [portIdxWidth-1:0]  rdPort;               // Port selected by the load
    gpioPkg::regSlot_e        rdSlot;               // Slot selected by the load
    logic                     rdMapped;             // Load address inside the map
    logic [portCount*32-1:0]  dataInQ;              // Data-in snapshot of all ports
    logic [31:0]              readWord;             // Selected word before the read flop

    // ##############################
    // Address split
    // ##############################
    assign wrPort   = lw.wordAddr[gpioPkg::busAddrWidth-3:gpioPkg::slotBits];
    assign wrSlot   = gpioPkg::regSlot_e'(lw.wordAddr[gpioPkg::slotBits-1:0]);
    assign wrMapped = int'(lw.wordAddr) < mappedWords;

    assign rdPort   = rdWordAddr[gpioPkg::busAddrWidth-3:gpioPkg::slotBits];
    assign rdSlot   = gpioPkg::regSlot_e'(rdWordAddr[gpioPkg::slotBits-1:0]);
    assign rdMapped = int'(rdWordAddr) < mappedWords;

    // ##############################
    // Control registers
    // ##############################
    // Enable and output data, one lane at a time
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            pinEnable <= '0;                        // All pins released
            pinOut    <= '0;
        end
        else
        begin
            for (int p = 0; p < portCount; p++)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (wrMapped && int'(wrPort) == p && lw.byteEn[b])
                    begin
                        if (wrSlot == gpioPkg::slotEnable)
                            pinEnable[p*32+b*8 +: 8] <= lw.data[b*8 +: 8];
                        else if (wrSlot == gpioPkg::slotDataOut)
                            pinOut[p*32+b*8 +: 8] <= lw.data[b*8 +: 8];
                        // Data-in and reserved slots ignore stores
                    end
                end
            end
        end
    end

    // ##############################
    // Snapshot and read path
    // ##############################
    always_comb
    begin
        readWord = '0;                              // Unmapped reads return zero
        for (int p = 0; p < portCount; p++)
        begin
            if (rdMapped && int'(rdPort) == p)
            begin
                case (rdSlot)
                    gpioPkg::slotDataIn:   readWord = dataInQ[p*32 +: 32];
                    gpioPkg::slotEnable:   readWord = pinEnable[p*32 +: 32];
                    gpioPkg::slotDataOut:  readWord = pinOut[p*32 +: 32];
                    gpioPkg::slotReserved: readWord = '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        dataInQ <= pinSync;                         // Refreshed every cycle
        if (rdEn)
            regData <= readWord;                    // Held until the next load
    end

    // The access unit must have dropped stores outside the map
    lanesMapped: assert property (@(posedge clk) disable iff (!rstn)
        (lw.byteEn != 4'b0000) |-> wrMapped)
        else $error("Lane write to unmapped word address %0h", lw.wordAddr);

endmodule

// File: hdl/busAccessUnit.sv
`timescale 1ns/1ps

module busAccessUnit #(
    parameter int portCount = 2
) (
    input  logic                               clk,
    input  logic                               rstn,
    input  gpioPkg::busReq_t                   req,
    input  logic [31:0]                        regData,
    output gpioPkg::laneWrite_t                lw,
    output logic [gpioPkg::busAddrWidth-3:0]   rdWordAddr,
    output logic                               rdEn,
    output logic [31:0]                        rdData,
    output logic                               rdValid,
    output logic                               accessError
);

    logic [1:0]            offset;                  // Byte offset in the word
    logic                  aligned;                 // Size and offset agree
    logic                  addrMapped;              // Address hits a port
    logic [3:0]            laneMask;                // Lanes touched by the access
    logic [31:0]           laneData;                // Store data replicated onto lanes
    logic [1:0]            ldOffset;                // Offset of the load in flight
    gpioPkg::accessSize_e  ldSize;                  // Size of the load in flight
    logic                  ldSigned;                // Sign flag of the load in flight
    logic [31:0]           ldShifted;               // Returned word moved down to bit 0

    // ##############################
    // Request decode
    // ##############################
    assign offset     = req.addr[1:0];
    assign addrMapped = int'(req.addr) < portCount * gpioPkg::portBytes;

    always_comb
    begin
        case (req.size)
            gpioPkg::sizeByte:
            begin
                aligned  = 1'b1;                    // Any offset
                laneMask = 4'b0001 << offset;
                laneData = {4{req.wrData[7:0]}};    // Same byte on every lane
            end
            gpioPkg::sizeHalf:
            begin
                aligned  = ~offset[0];              // Even offsets only
                laneMask = 4'b0011 << offset;
                laneData = {2{req.wrData[15:0]}};
            end
            gpioPkg::sizeWord:
            begin
                aligned  = (offset == 2'b00);
                laneMask = 4'b1111;
                laneData = req.wrData;
            end
            default:
            begin
                aligned  = 1'b0;                    // Undefined size counts as error
                laneMask = 4'b0000;
                laneData = req.wrData;
            end
        endcase
    end

    // Unmapped or misaligned stores never reach a lane
    assign lw.wordAddr = req.addr[gpioPkg::busAddrWidth-1:2];
    assign lw.byteEn   = (req.wrEn && aligned && addrMapped) ? laneMask : 4'b0000;
    assign lw.data     = laneData;

    // Unmapped loads still go through, the register block returns zero
    assign rdWordAddr = req.addr[gpioPkg::busAddrWidth-1:2];
    assign rdEn       = req.rdEn && aligned;

    // ##############################
    // Response timing
    // ##############################
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            rdValid     <= 1'b0;
            accessError <= 1'b0;
        end
        else
        begin
            rdValid     <= rdEn;                    // Data comes back one edge later
            accessError <= (req.wrEn || req.rdEn) && !aligned;
        end
    end

    // Load attributes follow the read by one cycle
    always_ff @(posedge clk)
    begin
        if (rdEn)
        begin
            ldOffset <= offset;
            ldSize   <= req.size;
            ldSigned <= req.isSigned;
        end
    end

    // ##############################
    // Load alignment and extension
    // ##############################
    assign ldShifted = regData >> {ldOffset, 3'b000};

    always_comb
    begin
        case (ldSize)
            gpioPkg::sizeByte: rdData = {{24{ldSigned & ldShifted[7]}}, ldShifted[7:0]};
            gpioPkg::sizeHalf: rdData = {{16{ldSigned & ldShifted[15]}}, ldShifted[15:0]};
            default:           rdData = regData;   // Word load, no shift
        endcase
    end

    // A request is a load or a store, never both
    singleStrobe: assert property (@(posedge clk) disable iff (!rstn)
        !(req.wrEn && req.rdEn))
        else $error("Store and load strobe in the same cycle");

endmodule

// File: hdl/gpioPkg.sv
package gpioPkg;

    // ##############################
    // Bus geometry
    // ##############################
    localparam int busAddrWidth = 16;               // Byte address width
    localparam int portBytes    = 16;               // Address span of one port
    localparam int wordsPerPort = portBytes / 4;    // Register slots per port
    localparam int slotBits     = 2;                // Slot field in word address

    // ##############################
    // Enums
    // ##############################
    // Load/store width
    typedef enum logic [1:0] {
        sizeByte = 2'd0,                            // 8 bit
        sizeHalf = 2'd1,                            // 16 bit
        sizeWord = 2'd2                             // 32 bit
    } accessSize_e;

    // Word within one port
    typedef enum logic [1:0] {
        slotDataIn   = 2'd0,                        // Pin snapshot, read only
        slotEnable   = 2'd1,                        // Output enable per pin
        slotDataOut  = 2'd2,                        // Output data per pin
        slotReserved = 2'd3                         // Reads zero
    } regSlot_e;

    // ##############################
    // Structs
    // ##############################
    // One CPU request, single cycle strobe
    typedef struct packed {
        logic [busAddrWidth-1:0] addr;              // Byte address
        accessSize_e             size;              // Access width
        logic                    isSigned;          // Sign extend loads
        logic [31:0]             wrData;            // Store data, LSB aligned
        logic                    wrEn;              // Store strobe
        logic                    rdEn;              // Load strobe
    } busReq_t;

    // Lane write into the register block
    typedef struct packed {
        logic [busAddrWidth-3:0] wordAddr;          // Word address
        logic [3:0]              byteEn;            // Zero means no write
        logic [31:0]             data;              // Already on its lanes
    } laneWrite_t;

endpackage
